/* design/deparser_pkg.sv */
`default_nettype none

package deparser_pkg;

    localparam int DATA_W      = 512;
    localparam int KEEP_W      = DATA_W / 8;
    localparam int N_CONT      = 4;
    localparam int N_ACTIONS   = 4;
    localparam int TABLE_DEPTH = 16;
    localparam int TABLE_AW    = 4;
    localparam int VLAN_ID_POS = 116;

    localparam logic [2:0]  DEPARSER_ID = 3'd5;
    localparam logic [15:0] CTRL_FLAG   = 16'hf2f1;

    // container type codes
    localparam logic [1:0] CT_2B = 2'd1;
    localparam logic [1:0] CT_4B = 2'd2;
    localparam logic [1:0] CT_6B = 2'd3;

    // packet FSM
    localparam logic [2:0] ST_IDLE    = 3'd0;
    localparam logic [2:0] ST_LOOKUP  = 3'd1;
    localparam logic [2:0] ST_FETCH   = 3'd2;
    localparam logic [2:0] ST_REWRITE = 3'd3;
    localparam logic [2:0] ST_LOAD    = 3'd4;
    localparam logic [2:0] ST_HEADER  = 3'd5;
    localparam logic [2:0] ST_PASS    = 3'd6;

    // table write FSM
    localparam logic TBL_IDLE  = 1'b0;
    localparam logic TBL_WRITE = 1'b1;

    // packet byte k sits at data[8k +: 8]
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        logic              last;
    } beat_t;

    typedef struct packed {
        logic [N_CONT-1:0][47:0] c6;
        logic [N_CONT-1:0][31:0] c4;
        logic [N_CONT-1:0][15:0] c2;
    } phv_t;

    typedef struct packed {
        logic [3:0] spare;
        logic [6:0] offset;
        logic [1:0] ctype;
        logic [1:0] cindex;
        logic       valid;
    } deparse_action_t;

    // slot 0 in the upper 16 bits
    typedef deparse_action_t [0:N_ACTIONS-1] action_entry_t;

    typedef struct packed {
        logic        valid;
        logic [6:0]  offset;
        logic [1:0]  ctype;
        logic [47:0] value;
    } deparse_field_t;

    typedef deparse_field_t [0:N_ACTIONS-1] field_set_t;

    typedef struct packed {
        logic [119:0] rsvd_hi;
        logic [7:0]   index;
        logic [7:0]   rsvd_b47;
        logic [7:0]   mod_id;
        logic [31:0]  rsvd_mid;
        logic [15:0]  flag;
        logic [319:0] rsvd_lo;
    } ctrl_hdr_t;

    // entry image in the low 8 bytes, byte 0 first
    typedef struct packed {
        logic [DATA_W-65:0] rsvd;
        logic [63:0]        image;
    } ctrl_entry_t;

    typedef union packed {
        ctrl_hdr_t   hdr;
        ctrl_entry_t entry;
    } ctrl_beat_u;

endpackage

`default_nettype wire

/* design/action_table.sv */
`timescale 1ns/1ps
`default_nettype none

module action_table (
    input  wire                               clk,
    input  wire                               aresetn,
    input  wire deparser_pkg::ctrl_beat_u     ctrl_tdata,
    input  wire                               ctrl_tvalid,
    input  wire                               ctrl_tlast,
    input  wire [deparser_pkg::TABLE_AW-1:0]  lookup_addr,
    output deparser_pkg::action_entry_t       entry
);
    import deparser_pkg::*;

    logic                wr_state;
    logic                wr_en;
    logic [TABLE_AW-1:0] wr_addr;
    logic [63:0]         image_be;
    action_entry_t       wr_data;
    logic                hdr_match;
    action_entry_t       mem [TABLE_DEPTH];

    assign hdr_match = ctrl_tvalid
                    && ctrl_tdata.hdr.mod_id[2:0] == DEPARSER_ID
                    && ctrl_tdata.hdr.flag == CTRL_FLAG;

    // beat byte 0 becomes the entry MSB
    always_comb begin
        for (int k = 0; k < 8; k++) begin
            image_be[63-8*k -: 8] = ctrl_tdata.entry.image[8*k +: 8];
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            wr_state <= TBL_IDLE;
            wr_en    <= 1'b0;
            wr_addr  <= '0;
        end else begin
            wr_en <= 1'b0;
            case (wr_state)
                TBL_IDLE: begin
                    if (hdr_match) begin
                        wr_en   <= 1'b1;
                        wr_addr <= ctrl_tdata.hdr.index[TABLE_AW-1:0];
                        if (!ctrl_tlast) begin
                            wr_state <= TBL_WRITE;
                        end
                    end
                end
                TBL_WRITE: begin
                    // burst continues at the next index
                    if (ctrl_tvalid) begin
                        wr_en   <= 1'b1;
                        wr_addr <= wr_addr + 1'b1;
                        if (ctrl_tlast) begin
                            wr_state <= TBL_IDLE;
                        end
                    end
                end
                default: begin
                    wr_state <= TBL_IDLE;
                end
            endcase
        end
    end

    // read sees the old entry on a same-cycle write
    always_ff @(posedge clk) begin
        wr_data <= image_be;
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        entry <= mem[lookup_addr];
    end

endmodule

`default_nettype wire

/* design/container_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module container_fetch (
    input  wire                                 clk,
    input  wire deparser_pkg::deparse_action_t  action,
    input  wire deparser_pkg::phv_t             phv,
    output deparser_pkg::deparse_field_t        field
);
    import deparser_pkg::*;

    logic        act_valid;
    logic [47:0] sel_value;

    // ctype zero means no container
    assign act_valid = action.valid && action.ctype != 2'b00;

    // left-aligned, MSB byte always at value[47:40]
    always_comb begin
        case (action.ctype)
            CT_2B: begin
                sel_value = {phv.c2[action.cindex], 32'h0};
            end
            CT_4B: begin
                sel_value = {phv.c4[action.cindex], 16'h0};
            end
            CT_6B: begin
                sel_value = phv.c6[action.cindex];
            end
            default: begin
                sel_value = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        field.valid  <= act_valid;
        field.offset <= action.offset;
        field.ctype  <= action.ctype;
        field.value  <= sel_value;
    end

endmodule

`default_nettype wire

/* design/header_rewriter.sv */
`timescale 1ns/1ps
`default_nettype none

module header_rewriter (
    input  wire                             clk,
    input  wire deparser_pkg::beat_t        hdr_in,
    input  wire deparser_pkg::field_set_t   fields,
    output deparser_pkg::beat_t             hdr_out
);
    import deparser_pkg::*;

    beat_t merged;

    // ascending slots, so a later slot overwrites an earlier one
    always_comb begin
        logic [7:0] len;
        logic [7:0] span;
        logic [6:0] base;

        merged = hdr_in;
        for (int s = 0; s < N_ACTIONS; s++) begin
            // ctype 1/2/3 gives 2/4/6 bytes
            len  = {5'd0, fields[s].ctype, 1'b0};
            base = fields[s].offset;
            span = {1'b0, base} + len;
            if (fields[s].valid && span <= 8'd64) begin
                for (int j = 0; j < 6; j++) begin
                    if (j < len) begin
                        merged.data[8*(base + j) +: 8] = fields[s].value[47-8*j -: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        hdr_out <= merged;
    end

endmodule

`default_nettype wire

/* design/deparse_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module deparse_ctrl (
    input  wire                               clk,
    input  wire                               aresetn,
    input  wire deparser_pkg::beat_t          pkt_head,
    input  wire                               pkt_empty,
    output logic                              pkt_rd_en,
    input  wire deparser_pkg::phv_t           phv_head,
    input  wire                               phv_empty,
    output logic                              phv_rd_en,
    output logic [deparser_pkg::TABLE_AW-1:0] lookup_addr,
    output deparser_pkg::phv_t                phv_hold,
    output deparser_pkg::beat_t               hdr_hold,
    input  wire deparser_pkg::beat_t          hdr_rewritten,
    output deparser_pkg::beat_t               out_beat,
    output logic                              out_valid,
    input  wire                               out_ready
);
    import deparser_pkg::*;

    logic [2:0] state;
    logic       start;
    logic       pass_load;
    logic       out_accept;

    assign start      = state == ST_IDLE && !pkt_empty && !phv_empty;
    assign out_accept = out_valid && out_ready;

    // no more loads once the tail beat sits in the output register
    assign pass_load = state == ST_PASS && !pkt_empty
                    && (!out_valid || (out_ready && !out_beat.last));

    assign pkt_rd_en = start || pass_load;
    assign phv_rd_en = start;

    // VLAN id bits 7:4
    assign lookup_addr = hdr_hold.data[VLAN_ID_POS+4 +: TABLE_AW];

    always_ff @(posedge clk) begin
        if (start) begin
            hdr_hold <= pkt_head;
            phv_hold <= phv_head;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_LOAD) begin
            out_beat <= hdr_rewritten;
        end else if (pass_load) begin
            out_beat <= pkt_head;
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            state     <= ST_IDLE;
            out_valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= ST_LOOKUP;
                    end
                end
                // table read in flight
                ST_LOOKUP: begin
                    state <= ST_FETCH;
                end
                // entry valid, fetch units register fields
                ST_FETCH: begin
                    state <= ST_REWRITE;
                end
                ST_REWRITE: begin
                    state <= ST_LOAD;
                end
                ST_LOAD: begin
                    out_valid <= 1'b1;
                    state     <= ST_HEADER;
                end
                ST_HEADER: begin
                    if (out_accept) begin
                        out_valid <= 1'b0;
                        if (out_beat.last) begin
                            state <= ST_IDLE;
                        end else begin
                            state <= ST_PASS;
                        end
                    end
                end
                ST_PASS: begin
                    if (pass_load) begin
                        out_valid <= 1'b1;
                    end else if (out_accept) begin
                        out_valid <= 1'b0;
                        if (out_beat.last) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                default: begin
                    state     <= ST_IDLE;
                    out_valid <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/deparser_top.sv */
`timescale 1ns/1ps
`default_nettype none

module deparser_top (
    input  wire                            clk,
    input  wire                            aresetn,
    input  wire deparser_pkg::beat_t       pkt_head,
    input  wire                            pkt_empty,
    output wire                            pkt_rd_en,
    input  wire deparser_pkg::phv_t        phv_head,
    input  wire                            phv_empty,
    output wire                            phv_rd_en,
    output wire deparser_pkg::beat_t       out_beat,
    output wire                            out_valid,
    input  wire                            out_ready,
    input  wire deparser_pkg::ctrl_beat_u  ctrl_tdata,
    input  wire                            ctrl_tvalid,
    input  wire                            ctrl_tlast
);
    import deparser_pkg::*;

    wire [TABLE_AW-1:0] lookup_addr;
    wire phv_t          phv_hold;
    wire beat_t         hdr_hold;
    wire beat_t         hdr_rewritten;
    wire action_entry_t entry;
    wire field_set_t    fields;

    deparse_ctrl u_ctrl (
        .clk           (clk),
        .aresetn       (aresetn),
        .pkt_head      (pkt_head),
        .pkt_empty     (pkt_empty),
        .pkt_rd_en     (pkt_rd_en),
        .phv_head      (phv_head),
        .phv_empty     (phv_empty),
        .phv_rd_en     (phv_rd_en),
        .lookup_addr   (lookup_addr),
        .phv_hold      (phv_hold),
        .hdr_hold      (hdr_hold),
        .hdr_rewritten (hdr_rewritten),
        .out_beat      (out_beat),
        .out_valid     (out_valid),
        .out_ready     (out_ready)
    );

    action_table u_table (
        .clk         (clk),
        .aresetn     (aresetn),
        .ctrl_tdata  (ctrl_tdata),
        .ctrl_tvalid (ctrl_tvalid),
        .ctrl_tlast  (ctrl_tlast),
        .lookup_addr (lookup_addr),
        .entry       (entry)
    );

    // one fetch unit per action slot
    for (genvar i = 0; i < N_ACTIONS; i++) begin : g_fetch
        container_fetch u_fetch (
            .clk    (clk),
            .action (entry[i]),
            .phv    (phv_hold),
            .field  (fields[i])
        );
    end

    header_rewriter u_rewriter (
        .clk     (clk),
        .hdr_in  (hdr_hold),
        .fields  (fields),
        .hdr_out (hdr_rewritten)
    );

endmodule

`default_nettype wire

/* tb/deparser_model.svh */
`ifndef DEPARSER_MODEL_SVH
`define DEPARSER_MODEL_SVH

logic [15:0]   lfsr_state = 16'd11;
beat_t         pkt_q[$];
phv_t          phv_q[$];
beat_t         exp_q[$];
action_entry_t shadow [TABLE_DEPTH];
logic [63:0]   burst_ent [4];

// taps 16, 14, 13, 11
function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
endfunction

function automatic logic [63:0] random_word(input int n);
    logic [63:0] w;
    w = '0;
    for (int i = 0; i < n; i++) begin
        w = {w[62:0], lfsr_bit()};
    end
    return w;
endfunction

function automatic deparse_action_t make_act(input logic v, input logic [1:0] ct,
                                             input logic [1:0] ci, input logic [6:0] off);
    return '{spare: 4'h0, offset: off, ctype: ct, cindex: ci, valid: v};
endfunction

// container bytes MSB first, slots in order, fields past byte 63 dropped
function automatic beat_t deparse_expected(input beat_t hdr, input phv_t phv,
                                           input action_entry_t ent);
    beat_t           res;
    deparse_action_t act;
    logic [47:0]     cont;
    int              len;
    int              off;
    res = hdr;
    for (int s = 0; s < N_ACTIONS; s++) begin
        act  = ent[s];
        off  = int'(act.offset);
        len  = 0;
        cont = '0;
        case (act.ctype)
            CT_2B: begin
                len  = 2;
                cont = {32'h0, phv.c2[act.cindex]};
            end
            CT_4B: begin
                len  = 4;
                cont = {16'h0, phv.c4[act.cindex]};
            end
            CT_6B: begin
                len  = 6;
                cont = phv.c6[act.cindex];
            end
            default: begin
                len = 0;
            end
        endcase
        if (act.valid && len != 0 && off + len <= 64) begin
            for (int j = 0; j < len; j++) begin
                res.data[8*(off + j) +: 8] = cont[8*(len - 1 - j) +: 8];
            end
        end
    end
    return res;
endfunction

task automatic queue_packet(input int vlan_idx, input int n_beats);
    beat_t b;
    phv_t  p;
    for (int w = 0; w < 6; w++) begin
        p[64*w +: 64] = random_word(64);
    end
    phv_q.push_back(p);
    for (int i = 0; i < n_beats; i++) begin
        for (int w = 0; w < 8; w++) begin
            b.data[64*w +: 64] = random_word(64);
        end
        b.keep = random_word(64);
        b.last = (i == n_beats - 1);
        if (i == 0) begin
            b.data[VLAN_ID_POS+4 +: TABLE_AW] = 4'(vlan_idx);
            exp_q.push_back(deparse_expected(b, p, shadow[vlan_idx]));
        end else begin
            exp_q.push_back(b);
        end
        pkt_q.push_back(b);
    end
endtask

`endif

/* tb/deparser_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module deparser_tb;
    import deparser_pkg::*;

    localparam int N_PKTS         = 20;
    localparam int TIMEOUT_CYCLES = 200 * N_PKTS + 50;

    logic       clk, aresetn;
    beat_t      pkt_head;
    logic       pkt_empty, pkt_rd_en;
    phv_t       phv_head;
    logic       phv_empty, phv_rd_en;
    beat_t      out_beat;
    logic       out_valid, out_ready;
    ctrl_beat_u ctrl_tdata;
    logic       ctrl_tvalid, ctrl_tlast;
    logic       stress, pkt_gap, phv_gap;
    int         cycles;
    beat_t      exp_beat;

    `include "deparser_model.svh"

    deparser_top uut (
        .clk         (clk),
        .aresetn     (aresetn),
        .pkt_head    (pkt_head),
        .pkt_empty   (pkt_empty),
        .pkt_rd_en   (pkt_rd_en),
        .phv_head    (phv_head),
        .phv_empty   (phv_empty),
        .phv_rd_en   (phv_rd_en),
        .out_beat    (out_beat),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .ctrl_tdata  (ctrl_tdata),
        .ctrl_tvalid (ctrl_tvalid),
        .ctrl_tlast  (ctrl_tlast)
    );

    always #4 clk = ~clk;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_beat(input beat_t got, input beat_t exp);
        if (got.data !== exp.data) begin
            stop_with_failure($sformatf("CHECK FAILED out_beat.data got %h expected %h",
                                        got.data, exp.data));
        end
        if (got.keep !== exp.keep) begin
            stop_with_failure($sformatf("CHECK FAILED out_beat.keep got %h expected %h",
                                        got.keep, exp.keep));
        end
    endtask

    task automatic check_last(input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("CHECK FAILED out_beat.last got %h expected %h",
                                        got, exp));
        end
    endtask

    // first beat carries the header, each beat carries one entry image
    task automatic write_entries(input logic [7:0] mod_id, input logic [15:0] flag,
                                 input logic [7:0] index, input int count);
        ctrl_beat_u beat;
        for (int i = 0; i < count; i++) begin
            beat = '0;
            if (i == 0) begin
                beat.hdr.flag   = flag;
                beat.hdr.mod_id = mod_id;
                beat.hdr.index  = index;
            end
            for (int k = 0; k < 8; k++) begin
                beat.entry.image[8*k +: 8] = burst_ent[i][63-8*k -: 8];
            end
            @(posedge clk);
            ctrl_tdata  <= beat;
            ctrl_tvalid <= 1'b1;
            ctrl_tlast  <= (i == count - 1);
            if (mod_id[2:0] == DEPARSER_ID && flag == CTRL_FLAG) begin
                shadow[(int'(index) + i) % TABLE_DEPTH] = burst_ent[i];
            end
        end
        @(posedge clk);
        ctrl_tvalid <= 1'b0;
        ctrl_tlast  <= 1'b0;
        repeat (4) @(posedge clk);
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || pkt_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
    endtask

    // show-ahead FIFO models and output ready
    always @(posedge clk) begin
        if (pkt_rd_en) begin
            pkt_q.delete(0);
        end
        if (phv_rd_en) begin
            phv_q.delete(0);
        end
        if (stress) begin
            out_ready <= lfsr_bit();
            pkt_gap = lfsr_bit() & lfsr_bit();
            phv_gap = lfsr_bit();
        end else begin
            out_ready <= 1'b1;
            pkt_gap = 1'b0;
            phv_gap = 1'b0;
        end
        pkt_empty <= pkt_gap || pkt_q.size() == 0;
        phv_empty <= phv_gap || phv_q.size() == 0;
        if (pkt_q.size() != 0) begin
            pkt_head <= pkt_q[0];
        end
        if (phv_q.size() != 0) begin
            phv_head <= phv_q[0];
        end
    end

    always @(posedge clk) begin
        if (aresetn && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                stop_with_failure("an output beat was accepted while no beat was expected");
            end else begin
                exp_beat = exp_q.pop_front();
                check_last(out_beat.last, exp_beat.last);
                check_beat(out_beat, exp_beat);
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            stop_with_failure("timeout: the output stream did not finish in time");
        end
    end

    initial begin
        clk         = 1'b0;
        aresetn     = 1'b0;
        pkt_head    = '0;
        pkt_empty   = 1'b1;
        phv_head    = '0;
        phv_empty   = 1'b1;
        out_ready   = 1'b1;
        ctrl_tdata  = '0;
        ctrl_tvalid = 1'b0;
        ctrl_tlast  = 1'b0;
        stress      = 1'b0;
        cycles      = 0;
        repeat (4) @(posedge clk);
        aresetn <= 1'b1;
        repeat (2) @(posedge clk);
        // one field per width at distinct offsets
        burst_ent[0] = {make_act(1'b1, CT_2B, 2'd1, 7'd2), make_act(1'b1, CT_4B, 2'd3, 7'd10),
                        make_act(1'b1, CT_6B, 2'd0, 7'd20), make_act(1'b0, CT_6B, 2'd2, 7'd40)};
        write_entries(8'h05, CTRL_FLAG, 8'd1, 1);
        // invalid slot, ctype 0, past the end, and a field ending at byte 63
        burst_ent[0] = {make_act(1'b0, CT_6B, 2'd1, 7'd0), make_act(1'b1, 2'd0, 2'd2, 7'd5),
                        make_act(1'b1, CT_6B, 2'd3, 7'd60), make_act(1'b1, CT_4B, 2'd2, 7'd60)};
        write_entries(8'h05, CTRL_FLAG, 8'd2, 1);
        // overlap at bytes 32..33
        burst_ent[0] = {make_act(1'b1, CT_6B, 2'd2, 7'd30), make_act(1'b1, CT_2B, 2'd0, 7'd32),
                        make_act(1'b1, CT_4B, 2'd1, 7'd62), make_act(1'b1, CT_2B, 2'd3, 7'd62)};
        write_entries(8'h05, CTRL_FLAG, 8'd3, 1);
        @(negedge clk);
        queue_packet(1, 1);
        queue_packet(1, 4);
        queue_packet(2, 1);
        queue_packet(3, 2);
        wait_drain();
        // wrong module id, then wrong flag
        burst_ent[0] = {4{make_act(1'b1, CT_6B, 2'd3, 7'd8)}};
        write_entries(8'h06, CTRL_FLAG, 8'd1, 1);
        write_entries(8'h05, 16'hf2f0, 8'd1, 1);
        @(negedge clk);
        queue_packet(1, 1);
        wait_drain();
        @(negedge clk);
        for (int i = 0; i < 3; i++) begin
            burst_ent[i] = random_word(64);
        end
        write_entries(8'h05, CTRL_FLAG, 8'd4, 3);
        @(negedge clk);
        queue_packet(4, 3);
        queue_packet(5, 1);
        queue_packet(6, 2);
        wait_drain();
        // random back-pressure and FIFO gaps
        @(negedge clk);
        stress = 1'b1;
        for (int i = 0; i < 12; i++) begin
            queue_packet(int'(random_word(8) % 6) + 1, int'(random_word(2)) + 1);
        end
        wait_drain();
        if (phv_q.size() != 0) begin
            stop_with_failure("packets were left over at the end of the run");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+tb
design/deparser_pkg.sv
design/action_table.sv
design/container_fetch.sv
design/header_rewriter.sv
design/deparse_ctrl.sv
design/deparser_top.sv
tb/deparser_tb.sv
